//--- sim.f
source/icache_cfg_pkg.sv
source/icache_msg_pkg.sv
source/mem_req_if.sv
source/mem_rtrn_if.sv
source/req_queue.sv
source/mem_responder.sv
source/rtrn_queue.sv
source/icache_mem_emul.sv
verif/icache_mem_emul_assert.sv
verif/icache_mem_checker.sv
verif/tb_icache_mem_emul.sv

//--- Bender.yml
package:
  name: icache_mem_emul

sources:
  - source/icache_cfg_pkg.sv
  - source/icache_msg_pkg.sv
  - source/mem_req_if.sv
  - source/mem_rtrn_if.sv
  - source/req_queue.sv
  - source/mem_responder.sv
  - source/rtrn_queue.sv
  - source/icache_mem_emul.sv
  - target: test
    files:
      - verif/icache_mem_emul_assert.sv
      - verif/icache_mem_checker.sv
      - verif/tb_icache_mem_emul.sv

//--- verif/tb_icache_mem_emul.sv
// emulator testbench; 256-word memory, seed 11, memory is filled by the write port before any read
`timescale 1ns/100ps

module tb_icache_mem_emul
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
();

  localparam int unsigned MEM_DEPTH  = 256;
  localparam int unsigned WAIT_LIMIT = 2000;
  localparam int unsigned N_REQ      = 200;
  localparam int unsigned LINE_BYTES = ICACHE_LINE_WIDTH / 8;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          mem_rand_en_i;
  logic                          req_valid_i;
  logic [PADDR_WIDTH-1:0]        req_paddr_i;
  logic                          req_nc_i;
  logic                          req_ack_o;
  logic                          wr_en_i;
  logic [PADDR_WIDTH-1:0]        wr_addr_i;
  logic [31:0]                   wr_data_i;
  logic                          wr_gnt_o;
  logic                          rtrn_vld_o;
  rtrn_type_e                    rtrn_type_o;
  logic [ICACHE_LINE_WIDTH-1:0]  rtrn_data_o;
  logic                          rtrn_nc_o;
  logic                          rtrn_f4b_o;
  logic [ICACHE_INDEX_WIDTH-1:0] rtrn_inv_idx_o;
  logic                          rtrn_inv_all_o;
  logic                          rtrn_rdy_i;
  integer                        seed;
  logic                          rdy_random;
  logic [PADDR_WIDTH-1:0]        addr;
  int                            err_count;
  int                            errs_mark;
  // set by a timeout so that all later waits are skipped
  logic                          aborted;

  always #50 clk_i = ~clk_i;

  icache_mem_emul #(.MEM_DEPTH(MEM_DEPTH)) icache_mem_emul_i (.*);

  icache_mem_checker #(.MEM_DEPTH(MEM_DEPTH)) chk_i (.*);

  // step to the next falling edge and redraw ready there in random mode
  task automatic next_cycle();
    @(negedge clk_i);
    rtrn_rdy_i = rdy_random ? 1'($random(seed)) : 1'b1;
  endtask

  task automatic finish_run();
    int total;
    total = err_count + chk_i.err_count;
    if (chk_i.ack_count != chk_i.fill_count || chk_i.gnt_count != chk_i.inv_count) begin
      $display("acks, grants and returns do not balance");
      total++;
    end
    $display("acks %0d grants %0d fills %0d invalidations %0d errors %0d", chk_i.ack_count,
             chk_i.gnt_count, chk_i.fill_count, chk_i.inv_count, total);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // a timeout skips every later wait and the run goes straight to its end
  task automatic abort_run(input string why);
    $display("%s", why);
    err_count++;
    aborted = 1'b1;
  endtask

  // called on a falling edge and holds the request until acked
  task automatic send_request(input logic [PADDR_WIDTH-1:0] paddr, input logic nc);
    logic acked;
    acked       = 1'b0;
    req_valid_i = 1'b1;
    req_paddr_i = paddr;
    req_nc_i    = nc;
    for (int cyc = 0; cyc < WAIT_LIMIT && !acked && !aborted; cyc++) begin
      @(posedge clk_i);
      acked = req_ack_o;
      next_cycle();
    end
    req_valid_i = 1'b0;
    if (!acked && !aborted) abort_run("request was not acknowledged in time");
  endtask

  task automatic send_write(input logic [PADDR_WIDTH-1:0] waddr, input logic [31:0] data);
    logic granted;
    granted   = 1'b0;
    wr_en_i   = 1'b1;
    wr_addr_i = waddr;
    wr_data_i = data;
    for (int cyc = 0; cyc < WAIT_LIMIT && !granted && !aborted; cyc++) begin
      @(posedge clk_i);
      granted = wr_gnt_o;
      next_cycle();
    end
    wr_en_i = 1'b0;
    if (!granted && !aborted) abort_run("write was not granted in time");
  endtask

  // every request and write has returned and the output queue is empty
  task automatic wait_drain();
    logic idle;
    idle = 1'b0;
    for (int cyc = 0; cyc < WAIT_LIMIT && !idle && !aborted; cyc++) begin
      next_cycle();
      idle = (chk_i.pending == 0) && !rtrn_vld_o;
    end
    if (!idle && !aborted) abort_run("returns did not drain in time");
  endtask

  // mixed cacheable and I/O requests at random addresses
  task automatic run_requests(input int n);
    logic                   nc;
    logic [PADDR_WIDTH-1:0] paddr;
    for (int i = 0; i < n; i++) begin
      nc    = 1'($random(seed));
      paddr = $random(seed);
      paddr = paddr & ~PADDR_WIDTH'(nc ? 3 : LINE_BYTES - 1);
      send_request(paddr, nc);
    end
    wait_drain();
  endtask

  task automatic report_test(input string name);
    int errs;
    errs      = err_count + chk_i.err_count - errs_mark;
    errs_mark = err_count + chk_i.err_count;
    $display("test %s done with %0d errors", name, errs);
  endtask

  initial begin
    seed          = 11;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    mem_rand_en_i = 1'b0;
    req_valid_i   = 1'b0;
    req_paddr_i   = '0;
    req_nc_i      = 1'b0;
    wr_en_i       = 1'b0;
    wr_addr_i     = '0;
    wr_data_i     = '0;
    rtrn_rdy_i    = 1'b1;
    rdy_random    = 1'b0;
    err_count     = 0;
    errs_mark     = 0;
    aborted       = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    next_cycle();
    if (rtrn_vld_o || req_ack_o || wr_gnt_o) begin
      $display("Mismatch rtrn_vld_o/req_ack_o/wr_gnt_o: got %0h expected 0",
               {rtrn_vld_o, req_ack_o, wr_gnt_o});
      err_count++;
    end
    report_test("reset");
    // every word gets a known value before any read
    for (int i = 0; i < MEM_DEPTH; i++) begin
      send_write(PADDR_WIDTH'(i * 4), $random(seed));
    end
    wait_drain();
    report_test("mem_fill");
    run_requests(N_REQ);
    report_test("requests");
    mem_rand_en_i = 1'b1;
    rdy_random    = 1'b1;
    run_requests(N_REQ);
    report_test("contention");
    // writes only while nothing is outstanding and then read the written line back
    for (int r = 0; r < 8; r++) begin
      for (int w = 0; w < 4; w++) begin
        addr = $random(seed) & ~PADDR_WIDTH'(3);
        send_write(addr, $random(seed));
      end
      send_request(addr & ~PADDR_WIDTH'(LINE_BYTES - 1), 1'b0);
      send_request(addr, 1'b1);
      run_requests(8);
    end
    report_test("write_read");
    finish_run();
  end

endmodule

//--- verif/icache_mem_checker.sv
// scoreboard on the emulator ports; assumes writes are only issued while no fill is outstanding
`timescale 1ns/100ps

module icache_mem_checker
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
#(
  parameter int unsigned MEM_DEPTH = 256
) (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic [PADDR_WIDTH-1:0]        req_paddr_i,
  input logic                          req_nc_i,
  input logic                          req_ack_o,
  input logic [PADDR_WIDTH-1:0]        wr_addr_i,
  input logic [31:0]                   wr_data_i,
  input logic                          wr_gnt_o,
  input logic                          rtrn_vld_o,
  input rtrn_type_e                    rtrn_type_o,
  input logic [ICACHE_LINE_WIDTH-1:0]  rtrn_data_o,
  input logic                          rtrn_nc_o,
  input logic                          rtrn_f4b_o,
  input logic [ICACHE_INDEX_WIDTH-1:0] rtrn_inv_idx_o,
  input logic                          rtrn_inv_all_o,
  input logic                          rtrn_rdy_i
);

  // model memory and outstanding work
  logic [31:0]                  model_mem [MEM_DEPTH];
  icache_req_t                  req_q [$];
  logic [PADDR_WIDTH-1:0]       inv_q [$];
  logic                         held = 1'b0;
  logic [ICACHE_LINE_WIDTH:0]   held_val;
  int ack_count = 0;
  int gnt_count = 0;
  int fill_count = 0;
  int inv_count = 0;
  int err_count = 0;
  int pending = 0;

  // line or single word as the cache should see it
  function automatic logic [ICACHE_LINE_WIDTH-1:0] expected_data(input icache_req_t req);
    logic [ICACHE_LINE_WIDTH-1:0] line;
    int unsigned                  base;
    line = '0;
    base = (req.paddr >> 2) % MEM_DEPTH;
    for (int k = 0; k < LINE_WORDS; k++) begin
      if (!req.nc || k == 0) begin
        line[k*32 +: 32] = model_mem[(base + k) % MEM_DEPTH];
      end
    end
    return line;
  endfunction

  task automatic compare(input string name, input logic [ICACHE_LINE_WIDTH:0] got,
                         input logic [ICACHE_LINE_WIDTH:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %0h expected %0h", name, got, exp);
      err_count++;
    end
  endtask

  always @(posedge clk_i) begin
    icache_req_t            req;
    logic [PADDR_WIDTH-1:0] waddr;
    if (rst_ni) begin
      // a return that was held off must stay put
      if (held && !rtrn_vld_o) begin
        $display("return was withdrawn before the cache accepted it");
        err_count++;
      end else if (held) begin
        compare("rtrn_type_o/rtrn_data_o", {rtrn_type_o, rtrn_data_o}, held_val);
      end
      held     = rtrn_vld_o && !rtrn_rdy_i;
      held_val = {rtrn_type_o, rtrn_data_o};
      if (rtrn_vld_o && rtrn_rdy_i) begin
        if (rtrn_type_o == IFILL_ACK && req_q.size() == 0) begin
          $display("fill returned while no request was pending");
          err_count++;
        end else if (rtrn_type_o == IFILL_ACK) begin
          req = req_q.pop_front();
          fill_count++;
          compare("rtrn_data_o", rtrn_data_o, expected_data(req));
          compare("rtrn_nc_o", rtrn_nc_o, req.nc);
          compare("rtrn_f4b_o", rtrn_f4b_o, req.nc);
        end else if (inv_q.size() == 0) begin
          $display("invalidation returned while no write was pending");
          err_count++;
        end else begin
          waddr = inv_q.pop_front();
          inv_count++;
          compare("rtrn_inv_idx_o", rtrn_inv_idx_o, waddr[ICACHE_INDEX_WIDTH-1:0]);
          compare("rtrn_inv_all_o", rtrn_inv_all_o, 1'b1);
        end
      end
      if (req_ack_o) begin
        req_q.push_back(icache_req_t'({req_paddr_i, req_nc_i}));
        ack_count++;
      end
      // write lands in the model at its grant edge
      if (wr_gnt_o) begin
        model_mem[(wr_addr_i >> 2) % MEM_DEPTH] = wr_data_i;
        inv_q.push_back(wr_addr_i);
        gnt_count++;
      end
      pending = req_q.size() + inv_q.size();
    end else begin
      held = 1'b0;
    end
  end

endmodule

//--- verif/icache_mem_emul_assert.sv
// port rules of the emulator, bound to every icache_mem_emul instance; checks hold only out of reset
`timescale 1ns/100ps

module icache_mem_emul_assert
  import icache_cfg_pkg::*;
(
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   req_valid_i,
  input logic [PADDR_WIDTH-1:0] req_paddr_i,
  input logic                   req_nc_i,
  input logic                   req_ack_o,
  input logic                   wr_en_i,
  input logic                   wr_gnt_o,
  input logic                   rtrn_vld_o
);

  localparam int unsigned LINE_BYTES = ICACHE_LINE_WIDTH / 8;

  // cacheable refills start on a line boundary
  a_line_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && !req_nc_i) |-> (req_paddr_i & PADDR_WIDTH'(LINE_BYTES - 1)) == '0)
    else $error("cacheable request address is not line aligned");

  // I/O reads are single words
  a_word_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && req_nc_i) |-> req_paddr_i[1:0] == 2'b00)
    else $error("non-cacheable request address is not word aligned");

  a_ack_needs_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_ack_o |-> req_valid_i)
    else $error("request acknowledged without a valid request");

  a_gnt_needs_en : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_gnt_o |-> wr_en_i)
    else $error("write granted without a write enable");

  // output queue comes out of reset empty
  a_idle_after_reset : assert property (@(posedge clk_i) $rose(rst_ni) |-> !rtrn_vld_o)
    else $error("return valid high in the first cycle after reset");

endmodule

bind icache_mem_emul icache_mem_emul_assert i_mem_emul_assert (.*);

//--- source/icache_mem_emul.sv
// memory emulator top; cacheable requests must be line aligned, nc requests word aligned
`timescale 1ns/100ps

module icache_mem_emul
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
#(
  parameter int unsigned MEM_DEPTH  = 1024,
  parameter int unsigned HIT_RATE   = 50,
  parameter int unsigned REQ_DEPTH  = 2,
  parameter int unsigned RTRN_DEPTH = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // contention enable
  input  logic                          mem_rand_en_i,
  // refill requests
  input  logic                          req_valid_i,
  input  logic [PADDR_WIDTH-1:0]        req_paddr_i,
  input  logic                          req_nc_i,
  output logic                          req_ack_o,
  // memory write port
  input  logic                          wr_en_i,
  input  logic [PADDR_WIDTH-1:0]        wr_addr_i,
  input  logic [31:0]                   wr_data_i,
  output logic                          wr_gnt_o,
  // returns to the cache
  output logic                          rtrn_vld_o,
  output rtrn_type_e                    rtrn_type_o,
  output logic [ICACHE_LINE_WIDTH-1:0]  rtrn_data_o,
  output logic                          rtrn_nc_o,
  output logic                          rtrn_f4b_o,
  output logic [ICACHE_INDEX_WIDTH-1:0] rtrn_inv_idx_o,
  output logic                          rtrn_inv_all_o,
  input  logic                          rtrn_rdy_i
);

  icache_req_t  req_in;
  icache_rtrn_t rtrn_out;

  mem_req_if  req_bus ();
  mem_rtrn_if rtrn_bus ();

  // pack plain request ports
  assign req_in.paddr = req_paddr_i;
  assign req_in.nc    = req_nc_i;

  req_queue #(
    .REQ_DEPTH (REQ_DEPTH)
  ) i_req_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (req_valid_i),
    .req_i   (req_in),
    .ack_o   (req_ack_o),
    .out_o   (req_bus.queue)
  );

  mem_responder #(
    .MEM_DEPTH (MEM_DEPTH),
    .HIT_RATE  (HIT_RATE)
  ) i_mem_responder (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rand_en_i (mem_rand_en_i),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .wr_gnt_o  (wr_gnt_o),
    .req_o     (req_bus.resp),
    .rtrn_o    (rtrn_bus.src)
  );

  rtrn_queue #(
    .RTRN_DEPTH (RTRN_DEPTH)
  ) i_rtrn_queue (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .in_i   (rtrn_bus.sink),
    .vld_o  (rtrn_vld_o),
    .rtrn_o (rtrn_out),
    .rdy_i  (rtrn_rdy_i)
  );

  // unpack the return struct
  assign rtrn_type_o    = rtrn_out.rtype;
  assign rtrn_data_o    = rtrn_out.data;
  assign rtrn_nc_o      = rtrn_out.nc;
  assign rtrn_f4b_o     = rtrn_out.f4b;
  assign rtrn_inv_idx_o = rtrn_out.inv_idx;
  assign rtrn_inv_all_o = rtrn_out.inv_all;

endmodule

//--- source/rtrn_queue.sv
// return output buffer; the head stays valid until accepted by ready, RTRN_DEPTH must be at least 1
`timescale 1ns/100ps

module rtrn_queue
  import icache_msg_pkg::*;
#(
  parameter int unsigned RTRN_DEPTH = 2
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  mem_rtrn_if.sink     in_i,
  output logic         vld_o,
  output icache_rtrn_t rtrn_o,
  input  logic         rdy_i
);

  localparam int unsigned PTR_W = (RTRN_DEPTH > 1) ? $clog2(RTRN_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(RTRN_DEPTH + 1);

  icache_rtrn_t     buf_q [RTRN_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             pop;

  // full stalls both writes and fills in the responder
  assign in_i.full = (count_q == CNT_W'(RTRN_DEPTH));

  // head towards the cache
  assign vld_o  = (count_q != '0);
  assign rtrn_o = buf_q[rd_ptr_q];
  assign pop    = vld_o & rdy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (in_i.push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(RTRN_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(RTRN_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (in_i.push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !in_i.push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // message storage
  always_ff @(posedge clk_i) begin
    if (in_i.push) begin
      buf_q[wr_ptr_q] <= in_i.rtrn;
    end
  end

endmodule

//--- source/mem_responder.sv
// word memory with write port and fill logic; MEM_DEPTH must be a power of two, upper address bits are ignored
`timescale 1ns/100ps

module mem_responder
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
#(
  parameter int unsigned MEM_DEPTH = 1024,
  parameter int unsigned HIT_RATE  = 50
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rand_en_i,
  input  logic                   wr_en_i,
  input  logic [PADDR_WIDTH-1:0] wr_addr_i,
  input  logic [31:0]            wr_data_i,
  output logic                   wr_gnt_o,
  mem_req_if.resp                req_o,
  mem_rtrn_if.src                rtrn_o
);

  // word address width inside the array
  localparam int unsigned AW = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

  // gate threshold on the low LFSR byte, 256 means always open
  localparam logic [8:0] HIT_THRESH = 9'((HIT_RATE * 256) / 100);

  // nonzero start value, an all-zero LFSR would lock up
  localparam logic [15:0] LFSR_SEED = 16'hACE1;

  logic [31:0]   mem_q [MEM_DEPTH];
  logic [15:0]   lfsr_q;
  logic          lfsr_fb;
  logic          gate_open;
  logic          fill_go;
  logic [AW-1:0] wr_waddr;
  logic [AW-1:0] rd_waddr;
  logic [31:0]   line_w [LINE_WORDS];
  icache_rtrn_t  rtrn_d;

  // contention source
  // taps 16,14,13,11 give a maximal length sequence
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LFSR_SEED;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_fb};
    end
  end

  // with contention off the memory is ready every cycle
  assign gate_open = ~rand_en_i | ({1'b0, lfsr_q[7:0]} < HIT_THRESH);

  // write port
  // a write needs a free return slot for its invalidation
  assign wr_gnt_o = wr_en_i & ~rtrn_o.full;
  assign wr_waddr = wr_addr_i[AW+1:2];

  always_ff @(posedge clk_i) begin
    if (wr_gnt_o) begin
      mem_q[wr_waddr] <= wr_data_i;
    end
  end

  // fill path
  // a granted write takes the return slot, so the fill waits a cycle
  assign fill_go   = ~wr_gnt_o & req_o.valid & ~rtrn_o.full & gate_open;
  assign req_o.pop = fill_go;

  // byte address to word address, wraps modulo MEM_DEPTH
  assign rd_waddr = req_o.req.paddr[AW+1:2];

  // consecutive words of the line, the sum wraps at AW bits
  for (genvar k = 0; k < LINE_WORDS; k++) begin : g_line
    assign line_w[k] = mem_q[rd_waddr + AW'(k)];
  end

  // return message build
  always_comb begin
    rtrn_d       = '0;
    rtrn_d.rtype = IFILL_ACK;
    if (wr_gnt_o) begin
      // no tag mirror here, so all ways of the index are dropped
      rtrn_d.rtype   = INV_REQ;
      rtrn_d.inv_idx = wr_addr_i[ICACHE_INDEX_WIDTH-1:0];
      rtrn_d.inv_all = 1'b1;
    end else if (req_o.req.nc) begin
      // I/O read, one word in lane 0 and upper lanes zero
      rtrn_d.nc         = 1'b1;
      rtrn_d.f4b        = 1'b1;
      rtrn_d.data[31:0] = line_w[0];
    end else begin
      for (int k = 0; k < LINE_WORDS; k++) begin
        rtrn_d.data[k*32 +: 32] = line_w[k];
      end
    end
  end

  // memory is read in the push cycle, earlier writes are visible
  assign rtrn_o.push = wr_gnt_o | fill_go;
  assign rtrn_o.rtrn = rtrn_d;

endmodule

//--- source/req_queue.sv
// request input buffer; ack is combinational on valid and not full, REQ_DEPTH must be at least 1
`timescale 1ns/100ps

module req_queue
  import icache_msg_pkg::*;
#(
  parameter int unsigned REQ_DEPTH = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        valid_i,
  input  icache_req_t req_i,
  output logic        ack_o,
  mem_req_if.queue    out_o
);

  localparam int unsigned PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(REQ_DEPTH + 1);

  icache_req_t      buf_q [REQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push;
  logic             pop;

  assign full  = (count_q == CNT_W'(REQ_DEPTH));
  // request is taken at the edge where it is acked
  assign ack_o = valid_i & ~full;
  assign push  = ack_o;

  // head goes to the responder
  assign out_o.valid = (count_q != '0);
  assign out_o.req   = buf_q[rd_ptr_q];
  assign pop         = out_o.pop & out_o.valid;

  // pointers wrap at REQ_DEPTH, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keep the count
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= req_i;
    end
  end

endmodule

//--- source/mem_rtrn_if.sv
// responder into the output queue; push must only be raised while full is low
`timescale 1ns/100ps

interface mem_rtrn_if
  import icache_msg_pkg::*;
();

  // write one return message this cycle
  logic         push;
  // message to store
  icache_rtrn_t rtrn;
  // output queue has no free slot
  logic         full;

  // responder side
  modport src (
    output push,
    output rtrn,
    input  full
  );

  // output queue side
  modport sink (
    input  push,
    input  rtrn,
    output full
  );

endinterface

//--- source/mem_req_if.sv
// head of the input queue towards the responder; the head is consumed when valid and pop are both high
`timescale 1ns/100ps

interface mem_req_if
  import icache_msg_pkg::*;
();

  // queue holds at least one request
  logic        valid;
  // oldest buffered request
  icache_req_t req;
  // responder consumes the head this cycle
  logic        pop;

  modport queue (
    output valid,
    output req,
    input  pop
  );

  modport resp (
    input  valid,
    input  req,
    output pop
  );

endinterface

//--- source/icache_msg_pkg.sv
// request and return messages between the cache and the emulator; widths come from the cfg package
package icache_msg_pkg;

  import icache_cfg_pkg::*;

  // return kinds sent back to the cache
  typedef enum logic [0:0] {
    IFILL_ACK = 1'b0,
    INV_REQ   = 1'b1
  } rtrn_type_e;

  // refill request, 33 bits
  typedef struct packed {
    logic [PADDR_WIDTH-1:0] paddr;
    // non-cacheable, single word read from I/O space
    logic                   nc;
  } icache_req_t;

  // return message, 144 bits
  typedef struct packed {
    rtrn_type_e                    rtype;
    logic [ICACHE_LINE_WIDTH-1:0]  data;
    logic                          nc;
    // only word 0 of data is valid
    logic                          f4b;
    logic [ICACHE_INDEX_WIDTH-1:0] inv_idx;
    // invalidate every way of inv_idx
    logic                          inv_all;
  } icache_rtrn_t;

endpackage

//--- source/icache_cfg_pkg.sv
// fixed cache and address geometry; the line must hold a whole number of 32-bit words
package icache_cfg_pkg;

  // physical byte address as seen by the instruction cache
  localparam int unsigned PADDR_WIDTH = 32;

  // one cache line is four 32-bit words
  localparam int unsigned ICACHE_LINE_WIDTH = 128;

  // words per line, used by the responder to assemble fills
  localparam int unsigned LINE_WORDS = ICACHE_LINE_WIDTH / 32;

  // byte-address bits that select a cache set
  // invalidations carry these bits of the written address
  localparam int unsigned ICACHE_INDEX_WIDTH = 12;

endpackage
